// File: bench/uop_trace.txt
# T name | R ready mode (0 low, 1 high, 2 random) | F count word0 word1 (hex)
# E op rd rs1 rs2 imm(hex) illegal tag | X redirect pulse | B expect fetch_ready low
T decode
E 1 5 6 0 fffffffd 0 0
E 0 1 2 3 00000000 0 1
E 2 7 2 0 00000008 0 2
E 3 0 2 9 fffffffc 0 3
E 4 0 1 2 fffffff8 0 4
E 5 10 0 0 12345000 0 5
E 6 0 0 0 00000000 1 6
F 1 ffd30293 00000000
F 1 003100b3 00000000
F 1 00812383 00000000
F 1 fe912e23 00000000
F 1 fe208ce3 00000000
F 1 12345537 00000000
F 1 ffffffff 00000000
T multi_issue
E 0 1 2 3 00000000 0 7
E 1 5 6 0 fffffffd 0 8
E 5 10 0 0 12345000 0 9
E 3 0 2 9 fffffffc 0 10
F 2 003100b3 ffd30293
F 2 12345537 fe912e23
T backpressure
E 0 1 2 3 00000000 0 11
E 1 5 6 0 fffffffd 0 12
E 0 1 2 3 00000000 0 13
E 1 5 6 0 fffffffd 0 14
E 0 1 2 3 00000000 0 15
E 1 5 6 0 fffffffd 0 16
R 0
F 2 003100b3 ffd30293
F 2 003100b3 ffd30293
F 2 003100b3 ffd30293
B
R 1
T random_gaps
R 2
E 0 1 2 3 00000000 0 17
E 1 5 6 0 fffffffd 0 18
E 5 10 0 0 12345000 0 19
E 3 0 2 9 fffffffc 0 20
F 2 003100b3 ffd30293
F 2 12345537 fe912e23
T flush
R 0
F 2 003100b3 ffd30293
F 2 12345537 fe912e23
X
R 1
E 4 0 1 2 fffffff8 0 25
E 2 7 2 0 00000008 0 26
F 2 fe208ce3 00812383
T load_use
E 2 7 2 0 00000008 0 27
E 0 1 7 3 00000000 0 28
E 2 0 2 0 00000008 0 29
E 0 1 0 3 00000000 0 30
F 2 00812383 003380b3
F 2 00812003 003000b3

// File: src.f
hw/uop_pkg.sv
hw/queue_ctrl_if.sv
hw/uop_decoder.sv
hw/decode_queue.sv
hw/hazard_unit.sv
hw/uop_issue_top.sv
bench/uop_checker.sv
bench/tb_uop_issue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the uop issue testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_uop_issue -f src.f -o sim_uop

# trace path in the testbench is relative to the project root
./obj_dir/sim_uop | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: bench/tb_uop_issue.sv
`timescale 1ns/1ps

module tb_uop_issue;

    localparam int    DISPATCH_SIZE = 2;
    localparam int    QUEUE_LEN     = 4;   // small queue, fills fast
    localparam int    TIMEOUT       = 200; // cycles per wait
    localparam string TRACE_FILE    = "bench/uop_trace.txt";

    logic                                        CLK;
    logic                                        nRST;
    logic                                        fetch_valid;
    logic [DISPATCH_SIZE-1:0][uop_pkg::XLEN-1:0] fetch_insts;
    logic [$clog2(DISPATCH_SIZE):0]              fetch_count;
    logic                                        fetch_ready;
    logic                                        ex_valid;
    uop_pkg::op_class_t                          ex_op;
    logic [3:0]                                  ex_funct;
    logic [uop_pkg::REG_W-1:0]                   ex_rd, ex_rs1, ex_rs2;
    logic [uop_pkg::XLEN-1:0]                    ex_imm;
    uop_pkg::tag_t                               ex_tag;
    logic                                        ex_illegal;
    logic                                        ex_ready;
    logic                                        redirect;

    logic          exp_push, blocked_chk, test_end;
    uop_pkg::uop_t exp_uop;
    logic [8*16-1:0] test_name;
    int            pending, tests_pass, tests_fail;
    int            seed;
    int            ready_mode; // 0 low, 1 high, 2 random gaps
    logic          hung;

    uop_issue_top #(.QUEUE_LEN(QUEUE_LEN), .DISPATCH_SIZE(DISPATCH_SIZE)) dut (.*);

    uop_checker #(.DISPATCH_SIZE(DISPATCH_SIZE)) chk (
        .CLK(CLK), .nRST(nRST), .ex_valid(ex_valid), .ex_ready(ex_ready),
        .ex_op(ex_op), .ex_funct(ex_funct), .ex_rd(ex_rd), .ex_rs1(ex_rs1),
        .ex_rs2(ex_rs2), .ex_imm(ex_imm), .ex_tag(ex_tag), .ex_illegal(ex_illegal),
        .redirect(redirect), .fetch_valid(fetch_valid), .fetch_insts(fetch_insts),
        .fetch_count(fetch_count), .fetch_ready(fetch_ready), .exp_push(exp_push),
        .exp_uop(exp_uop), .blocked_chk(blocked_chk), .test_end(test_end),
        .test_name(test_name), .pending(pending), .tests_pass(tests_pass),
        .tests_fail(tests_fail)
    );

    always #2 CLK = ~CLK; // 4 ns period

    task automatic next_cycle();
        @(negedge CLK);
        case (ready_mode)
            0:       ex_ready = 1'b0;
            1:       ex_ready = 1'b1;
            default: ex_ready = 1'($random(seed)); // gaps
        endcase
    endtask

    task automatic send_group(input int cnt, input logic [31:0] w0, input logic [31:0] w1);
        int waited;
        waited      = 0;
        fetch_count = 2'(cnt);
        fetch_insts = {w1, w0}; // lane 0 is oldest
        fetch_valid = 1'b1;
        #1;
        while (!fetch_ready && waited < TIMEOUT) begin
            next_cycle();
            #1;
            waited++;
        end
        if (!fetch_ready) begin
            $display("fetch group was never accepted, fetch_ready stayed low");
            hung = 1'b1;
        end
        next_cycle(); // transfer happened on the edge
        fetch_valid = 1'b0;
    endtask

    task automatic push_expected(input int op, input int rd, input int rs1, input int rs2,
                                 input logic [31:0] imm, input int ill, input int tag);
        exp_uop         = '0;
        exp_uop.valid   = 1'b1;
        exp_uop.op      = uop_pkg::op_class_t'(op);
        exp_uop.rd      = 5'(rd);
        exp_uop.rs1     = 5'(rs1);
        exp_uop.rs2     = 5'(rs2);
        exp_uop.imm     = imm;
        exp_uop.illegal = 1'(ill);
        exp_uop.tag     = 8'(tag);
        exp_push = 1'b1;
        next_cycle();
        exp_push = 1'b0;
    endtask

    // drain, then let the checker close the test
    task automatic end_test();
        int waited;
        waited = 0;
        while (pending != 0 && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (pending != 0) $display("drain timed out with %0d uops outstanding", pending);
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
    endtask

    initial begin
        string line;
        byte   c;
        int    fd, n, cnt, op, rd, rs1, rs2, ill, tag;
        logic [31:0] a, b, imm;
        logic [8*16-1:0] name;
        bit    in_test;
        CLK         = 1'b0;
        nRST        = 1'b0;
        fetch_valid = 1'b0;
        fetch_insts = '0;
        fetch_count = '0;
        ex_ready    = 1'b0;
        redirect    = 1'b0;
        exp_push    = 1'b0;
        exp_uop     = '0;
        blocked_chk = 1'b0;
        test_end    = 1'b0;
        test_name   = '0;
        seed        = 32'h1af2_c208;
        ready_mode  = 1;
        hung        = 1'b0;
        in_test     = 0;
        repeat (10) @(posedge CLK);
        next_cycle();
        nRST = 1'b1;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open trace file %0s", TRACE_FILE);
            hung = 1'b1;
        end
        while (!hung && fd != 0 && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() == 0) continue;
            c = line.getc(0);
            case (c)
                "T": begin
                    if (in_test) end_test();
                    n = $sscanf(line, "T %s", name);
                    test_name  = name;
                    ready_mode = 1; // each test starts with ex_ready high
                    in_test    = 1;
                end
                "R": n = $sscanf(line, "R %d", ready_mode);
                "F": begin
                    n = $sscanf(line, "F %d %h %h", cnt, a, b);
                    send_group(cnt, a, b);
                end
                "E": begin
                    n = $sscanf(line, "E %d %d %d %d %h %d %d", op, rd, rs1, rs2, imm, ill, tag);
                    push_expected(op, rd, rs1, rs2, imm, ill, tag);
                end
                "X": begin
                    redirect = 1'b1; // one cycle pulse
                    next_cycle();
                    redirect = 1'b0;
                    next_cycle();
                end
                "B": begin
                    blocked_chk = 1'b1;
                    next_cycle();
                    blocked_chk = 1'b0;
                end
                default: ; // comment or blank line
            endcase
        end
        if (in_test && !hung) end_test();
        $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
        if (hung || tests_fail != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

// File: bench/uop_checker.sv
`timescale 1ns/1ps

// watches the execute port and compares every consumed uop with the trace
module uop_checker #(
    parameter int DISPATCH_SIZE = 2
) (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  logic                                        ex_valid,
    input  logic                                        ex_ready,
    input  uop_pkg::op_class_t                          ex_op,
    input  logic [3:0]                                  ex_funct,
    input  logic [uop_pkg::REG_W-1:0]                   ex_rd,
    input  logic [uop_pkg::REG_W-1:0]                   ex_rs1,
    input  logic [uop_pkg::REG_W-1:0]                   ex_rs2,
    input  logic [uop_pkg::XLEN-1:0]                    ex_imm,
    input  uop_pkg::tag_t                               ex_tag,
    input  logic                                        ex_illegal,
    input  logic                                        redirect,
    input  logic                                        fetch_valid,
    input  logic [DISPATCH_SIZE-1:0][uop_pkg::XLEN-1:0] fetch_insts,
    input  logic [$clog2(DISPATCH_SIZE):0]              fetch_count,
    input  logic                                        fetch_ready,
    input  logic                                        exp_push,    // exp_uop joins the queue
    input  uop_pkg::uop_t                               exp_uop,
    input  logic                                        blocked_chk, // fetch_ready must be low
    input  logic                                        test_end,
    input  logic [8*16-1:0]                             test_name,
    output int                                          pending,     // expected uops not yet seen
    output int                                          tests_pass,
    output int                                          tests_fail
);

    uop_pkg::uop_t            exp_q[$];
    uop_pkg::uop_t            e;
    int                       test_errs;
    logic                     redir_d;   // redirect seen on the previous edge
    logic [uop_pkg::XLEN-1:0] word_by_tag [2**uop_pkg::TAG_W]; // accepted words by tag
    uop_pkg::tag_t            next_tag;  // tag of the next accepted word

    // funct is {inst[30], funct3}
    // lui and unknown opcodes carry none
    function automatic logic [3:0] expected_funct(input uop_pkg::op_class_t op,
                                                  input logic [uop_pkg::XLEN-1:0] inst);
        if (op == uop_pkg::op_lui || op == uop_pkg::op_illegal) begin
            return 4'b0;
        end
        return {inst[30], inst[14:12]};
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %0t: uop tag %0d field %0s got %h expected %h",
                     $time, e.tag, name, got, exp);
            test_errs++;
        end
    endtask

    always @(posedge CLK) begin
        if (!nRST) begin
            tests_pass = 0;
            tests_fail = 0;
            test_errs  = 0;
            redir_d    = 1'b0;
            next_tag   = '0;
        end else begin
            if (fetch_valid && fetch_ready) begin // group accepted, lane 0 gets the lowest tag
                for (int i = 0; i < int'(fetch_count); i++) begin
                    word_by_tag[next_tag + uop_pkg::tag_t'(i)] = fetch_insts[i];
                end
                next_tag = next_tag + uop_pkg::tag_t'(fetch_count);
            end
            if (exp_push) exp_q.push_back(exp_uop);
            if (ex_valid && ex_ready) begin // handshake
                if (exp_q.size() == 0) begin
                    $display("uop with tag %0d arrived when none was expected", ex_tag);
                    test_errs++;
                end else begin
                    e = exp_q.pop_front();
                    compare_field("tag", 32'(ex_tag), 32'(e.tag)); // program order
                    compare_field("op", 32'(ex_op), 32'(e.op));
                    compare_field("funct", 32'(ex_funct),
                                  32'(expected_funct(e.op, word_by_tag[e.tag])));
                    compare_field("rd", 32'(ex_rd), 32'(e.rd));
                    compare_field("rs1", 32'(ex_rs1), 32'(e.rs1));
                    compare_field("rs2", 32'(ex_rs2), 32'(e.rs2));
                    compare_field("imm", ex_imm, e.imm);
                    compare_field("illegal", 32'(ex_illegal), 32'(e.illegal));
                end
            end
            if (redir_d && ex_valid) begin
                $display("ex_valid was high in the cycle right after a redirect");
                test_errs++;
            end
            redir_d = redirect;
            if (blocked_chk && fetch_ready) begin
                $display("fetch_ready stayed high although the queue should be full");
                test_errs++;
            end
            if (test_end) begin
                if (exp_q.size() != 0) begin
                    $display("%0d expected uops never arrived", exp_q.size());
                    test_errs++;
                end
                if (test_errs == 0) tests_pass++;
                else tests_fail++;
                $display("test %0s: %0s", test_name, (test_errs == 0) ? "pass" : "fail");
                exp_q.delete();
                test_errs = 0;
            end
        end
        pending = exp_q.size();
    end

endmodule

// File: hw/uop_issue_top.sv
`timescale 1ns/1ps

module uop_issue_top #(
    parameter int QUEUE_LEN     = 8,
    parameter int DISPATCH_SIZE = 2
) (
    input  logic                                       CLK,
    input  logic                                       nRST,
    // fetch side
    input  logic                                       fetch_valid,
    input  logic [DISPATCH_SIZE-1:0][uop_pkg::XLEN-1:0] fetch_insts,
    input  logic [$clog2(DISPATCH_SIZE):0]             fetch_count,
    output logic                                       fetch_ready,
    // execute side
    output logic                                       ex_valid,
    output uop_pkg::op_class_t                         ex_op,
    output logic [3:0]                                 ex_funct,
    output logic [uop_pkg::REG_W-1:0]                  ex_rd,
    output logic [uop_pkg::REG_W-1:0]                  ex_rs1,
    output logic [uop_pkg::REG_W-1:0]                  ex_rs2,
    output logic [uop_pkg::XLEN-1:0]                   ex_imm,
    output uop_pkg::tag_t                              ex_tag,
    output logic                                       ex_illegal,
    input  logic                                       ex_ready,
    input  logic                                       redirect    // one cycle pulse
);

    queue_ctrl_if ctrl ();

    uop_pkg::uop_t [DISPATCH_SIZE-1:0] dec_uops; // decoder register to queue
    logic [$clog2(DISPATCH_SIZE):0]    dec_num;
    uop_pkg::uop_t                     head;     // queue head slot

    uop_decoder #(
        .DISPATCH_SIZE(DISPATCH_SIZE)
    ) u_decoder (
        .CLK        (CLK),
        .nRST       (nRST),
        .fetch_valid(fetch_valid),
        .fetch_insts(fetch_insts),
        .fetch_count(fetch_count),
        .fetch_ready(fetch_ready),
        .ctrl       (ctrl),
        .uops       (dec_uops),
        .num_uops   (dec_num)
    );

    decode_queue #(
        .D_TYPE       (uop_pkg::uop_t),
        .QUEUE_LEN    (QUEUE_LEN),
        .DISPATCH_SIZE(DISPATCH_SIZE)
    ) u_queue (
        .CLK     (CLK),
        .nRST    (nRST),
        .ctrls   (dec_uops),
        .num_uops(dec_num),
        .ctrl    (ctrl),
        .ex_in   (head)
    );

    hazard_unit u_hazard (
        .CLK     (CLK),
        .nRST    (nRST),
        .ex_ready(ex_ready),
        .redirect(redirect),
        .ctrl    (ctrl),
        .ex_valid(ex_valid)
    );

    // head fields out to execute, qualified by ex_valid
    assign ex_op      = head.op;
    assign ex_funct   = head.funct;
    assign ex_rd      = head.rd;
    assign ex_rs1     = head.rs1;
    assign ex_rs2     = head.rs2;
    assign ex_imm     = head.imm;
    assign ex_tag     = head.tag;
    assign ex_illegal = head.illegal;

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         ex_ready,
    input  logic         redirect,
    queue_ctrl_if.hazard ctrl,
    output logic         ex_valid
);

    logic                      load_pend; // load issued last cycle
    logic [uop_pkg::REG_W-1:0] load_rd;   // its destination
    logic                      head_is_load;
    logic                      interlock;
    logic                      issue;     // head consumed this edge

    assign head_is_load = ctrl.head_uop.op == uop_pkg::op_load;

    // one bubble when the head reads the register the load is still fetching
    // load_pend only sets for rd != 0, x0 never interlocks
    assign interlock = load_pend && ctrl.head_uop.valid &&
                       ((ctrl.head_uop.rs1 == load_rd) || (ctrl.head_uop.rs2 == load_rd));

    assign ex_valid = ctrl.head_uop.valid && !interlock && !redirect;
    assign issue    = ex_valid && ex_ready;

    assign ctrl.stall_queue = !ex_ready || interlock;
    assign ctrl.flush_queue = redirect;

    // interlock cycle issues nothing, so the pending flag drops after one cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            load_pend <= 1'b0;
        end else begin
            load_pend <= issue && head_is_load && (ctrl.head_uop.rd != '0);
        end
    end

    always_ff @(posedge CLK) begin
        if (issue) begin
            load_rd <= ctrl.head_uop.rd; // only read while load_pend
        end
    end

endmodule

// File: hw/decode_queue.sv
`timescale 1ns/1ps

module decode_queue #(
    parameter type D_TYPE        = uop_pkg::uop_t,
    parameter int  QUEUE_LEN     = 8,
    parameter int  DISPATCH_SIZE = 2
) (
    input  logic                           CLK,
    input  logic                           nRST,
    input  D_TYPE [DISPATCH_SIZE-1:0]      ctrls,
    input  logic [$clog2(DISPATCH_SIZE):0] num_uops,
    queue_ctrl_if.queue                    ctrl,
    output D_TYPE                          ex_in
);

    // counters wide enough for a full queue plus one incoming group
    localparam int CNT_W  = $clog2(QUEUE_LEN + DISPATCH_SIZE + 1);
    localparam int LANE_W = (DISPATCH_SIZE > 1) ? $clog2(DISPATCH_SIZE) : 1;

    // slots numbered 1..QUEUE_LEN, slot 1 is the head
    D_TYPE [QUEUE_LEN:1] queue_data;
    D_TYPE [QUEUE_LEN:1] nxt_queue_data;
    D_TYPE [QUEUE_LEN:1] shifted_data;   // queue after one pop

    logic [CNT_W-1:0]  tail_idx;         // occupied slots, 0 = empty
    logic [CNT_W-1:0]  nxt_tail_idx;
    logic [CNT_W-1:0]  kept_cnt;         // entries left after this cycle's pop
    logic [CNT_W-1:0]  free_slots;
    logic [CNT_W-1:0]  in_cnt;           // incoming group size
    logic              pop;
    logic              store;
    logic              full;
    logic [LANE_W-1:0] lane;             // ctrls lane feeding a slot

    assign pop    = !ctrl.stall_queue;   // head leaves whenever not held
    assign in_cnt = CNT_W'(num_uops);

    // an empty queue pops nothing
    assign kept_cnt   = (pop && (tail_idx != '0)) ? tail_idx - CNT_W'(1) : tail_idx;
    assign free_slots = CNT_W'(QUEUE_LEN) - kept_cnt;

    assign full  = free_slots < in_cnt;  // includes the simultaneous pop
    assign store = (in_cnt != '0) && !full;

    assign ctrl.queue_full = full;

    // shift toward the head
    always_comb begin
        for (int i = 1; i < QUEUE_LEN; i++) begin
            shifted_data[i] = queue_data[i+1];
        end
        shifted_data[QUEUE_LEN] = '0; // nop enters at the back
    end

    // slots up to kept_cnt keep (shifted) entries
    // the new group lands right behind them, the rest become nops
    always_comb begin
        lane = '0;
        for (int i = 1; i <= QUEUE_LEN; i++) begin
            nxt_queue_data[i] = '0;
            if (!ctrl.flush_queue) begin
                if (CNT_W'(i) <= kept_cnt) begin
                    nxt_queue_data[i] = pop ? shifted_data[i] : queue_data[i];
                end else if (store && (CNT_W'(i) <= kept_cnt + in_cnt)) begin
                    lane = LANE_W'(CNT_W'(i) - kept_cnt - CNT_W'(1));
                    nxt_queue_data[i] = ctrls[lane]; // lane 0 is oldest
                end
            end
        end
    end

    always_comb begin
        if (ctrl.flush_queue) begin
            nxt_tail_idx = '0;
        end else if (store) begin
            nxt_tail_idx = kept_cnt + in_cnt;
        end else begin
            nxt_tail_idx = kept_cnt;
        end
    end

    // zero slots are nops, so the head reads invalid out of reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            tail_idx   <= '0;
            queue_data <= '0;
        end else begin
            tail_idx   <= nxt_tail_idx;
            queue_data <= nxt_queue_data;
        end
    end

    assign ex_in         = queue_data[1];
    assign ctrl.head_uop = queue_data[1]; // interlock looks at the same slot

endmodule

// File: hw/uop_decoder.sv
`timescale 1ns/1ps

module uop_decoder #(
    parameter int DISPATCH_SIZE = 2
) (
    input  logic                                       CLK,
    input  logic                                       nRST,
    input  logic                                       fetch_valid,
    input  logic [DISPATCH_SIZE-1:0][uop_pkg::XLEN-1:0] fetch_insts,
    input  logic [$clog2(DISPATCH_SIZE):0]             fetch_count,
    output logic                                       fetch_ready,
    queue_ctrl_if.decoder                              ctrl,
    output uop_pkg::uop_t [DISPATCH_SIZE-1:0]          uops,
    output logic [$clog2(DISPATCH_SIZE):0]             num_uops
);

    uop_pkg::uop_t [DISPATCH_SIZE-1:0] dec_uops; // decode of the words on the fetch port
    uop_pkg::uop_t [DISPATCH_SIZE-1:0] grp_q;    // held group
    logic [$clog2(DISPATCH_SIZE):0]    cnt_q;    // words in grp_q, 0 = empty
    uop_pkg::tag_t                     tag_cnt;  // tag of the next accepted word
    logic                              grp_taken;
    logic                              fetch_xfer;

    // one word to one uop
    // fields a class does not use stay zero so the interlock never matches them
    function automatic uop_pkg::uop_t decode_word(input logic [uop_pkg::XLEN-1:0] inst,
                                                  input uop_pkg::tag_t tag);
        uop_pkg::uop_t u;
        u = '0;
        u.valid = 1'b1;
        u.tag = tag;
        u.funct = {inst[30], inst[14:12]};
        case (inst[6:0])
            uop_pkg::opc_alu_reg: begin
                u.op = uop_pkg::op_alu_reg;
                u.rd = inst[11:7];
                u.rs1 = inst[19:15];
                u.rs2 = inst[24:20];
            end
            uop_pkg::opc_alu_imm: begin
                u.op = uop_pkg::op_alu_imm;
                u.rd = inst[11:7];
                u.rs1 = inst[19:15];
                u.imm = {{20{inst[31]}}, inst[31:20]}; // I
            end
            uop_pkg::opc_load: begin
                u.op = uop_pkg::op_load;
                u.rd = inst[11:7];
                u.rs1 = inst[19:15];
                u.imm = {{20{inst[31]}}, inst[31:20]}; // I
            end
            uop_pkg::opc_store: begin
                u.op = uop_pkg::op_store;
                u.rs1 = inst[19:15];
                u.rs2 = inst[24:20];
                u.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]}; // S
            end
            uop_pkg::opc_branch: begin
                u.op = uop_pkg::op_branch;
                u.rs1 = inst[19:15];
                u.rs2 = inst[24:20];
                u.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                         inst[11:8], 1'b0}; // B, bit 0 always zero
            end
            uop_pkg::opc_lui: begin
                u.op = uop_pkg::op_lui;
                u.funct = '0; // no funct3 in U format
                u.rd = inst[11:7];
                u.imm = {inst[31:12], 12'b0}; // U
            end
            default: begin
                u.op = uop_pkg::op_illegal;
                u.funct = '0;
                u.illegal = 1'b1; // valid stays set, execute sees it
            end
        endcase
        return u;
    endfunction

    // lanes at or above fetch_count decode to nops
    always_comb begin
        for (int i = 0; i < DISPATCH_SIZE; i++) begin
            if (i < int'(fetch_count)) begin
                dec_uops[i] = decode_word(fetch_insts[i], tag_cnt + uop_pkg::tag_t'(i));
            end else begin
                dec_uops[i] = '0;
            end
        end
    end

    assign grp_taken   = (cnt_q != '0) && !ctrl.queue_full; // queue stores it this edge
    assign fetch_ready = !ctrl.flush_queue && ((cnt_q == '0) || !ctrl.queue_full);
    assign fetch_xfer  = fetch_valid && fetch_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt_q   <= '0;
            tag_cnt <= '0;
        end else if (ctrl.flush_queue) begin
            cnt_q <= '0; // held group is wrong path, tags keep counting
        end else if (fetch_xfer) begin
            cnt_q   <= fetch_count;
            tag_cnt <= tag_cnt + uop_pkg::tag_t'(fetch_count);
        end else if (grp_taken) begin
            cnt_q <= '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (fetch_xfer) begin
            grp_q <= dec_uops;
        end
    end

    assign uops     = grp_q;
    assign num_uops = cnt_q;

endmodule

// File: hw/queue_ctrl_if.sv
`timescale 1ns/1ps

// control and status between hazard unit, uop queue and decoder
interface queue_ctrl_if;

    logic          stall_queue; // hold queue, no pop this cycle
    logic          flush_queue; // drop everything queued or held
    logic          queue_full;  // incoming group does not fit
    uop_pkg::uop_t head_uop;    // head slot, seen by the interlock

    modport queue (
        input  stall_queue,
        input  flush_queue,
        output queue_full,
        output head_uop
    );

    modport hazard (
        output stall_queue,
        output flush_queue,
        input  head_uop
    );

    modport decoder (
        input queue_full,
        input flush_queue
    );

    modport top (
        input stall_queue,
        input flush_queue,
        input queue_full,
        input head_uop
    );

endinterface

// File: hw/uop_pkg.sv
package uop_pkg;

    localparam int REG_W = 5;  // register index width
    localparam int XLEN  = 32; // instruction word and immediate
    localparam int TAG_W = 8;  // sequence tag, wraps

    typedef logic [TAG_W-1:0] tag_t;

    // uop class, 3 bits
    typedef enum logic [2:0] {
        op_alu_reg = 3'd0,
        op_alu_imm = 3'd1,
        op_load    = 3'd2,
        op_store   = 3'd3,
        op_branch  = 3'd4,
        op_lui     = 3'd5,
        op_illegal = 3'd6
    } op_class_t;

    // rv32i major opcodes handled by the decoder
    localparam logic [6:0] opc_alu_reg = 7'b0110011;
    localparam logic [6:0] opc_alu_imm = 7'b0010011;
    localparam logic [6:0] opc_load    = 7'b0000011;
    localparam logic [6:0] opc_store   = 7'b0100011;
    localparam logic [6:0] opc_branch  = 7'b1100011;
    localparam logic [6:0] opc_lui     = 7'b0110111;

    // one micro-op
    // an all-zero entry is a nop, so queue slots clear to zero
    typedef struct packed {
        logic             valid;   // slot holds a real uop
        op_class_t        op;
        logic [3:0]       funct;   // {inst[30], funct3}
        logic [REG_W-1:0] rd;      // zero when the class writes nothing
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;     // zero when the class reads no rs2
        logic [XLEN-1:0]  imm;     // sign-extended
        tag_t             tag;     // program order stamp
        logic             illegal; // unknown opcode, passed on untrapped
    } uop_t;

endpackage
